//--- filelist.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/board_pkg.sv
verilog/csr_if.sv
verilog/clock_enables.sv
verilog/input_sync.sv
verilog/board_regs.sv
verilog/watchdog.sv
verilog/intc.sv
verilog/board_ctrl_top.sv
dv/board_ctrl_assertions.sv
dv/board_ctrl_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module board_ctrl_tb -o Vboard_ctrl_tb

out=$(./obj_dir/Vboard_ctrl_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- dv/board_ctrl_tb.sv
// Board controller testbench
`default_nettype none
`include "board_defines.svh"

module board_ctrl_tb;
	localparam logic [7:0] VERSION = 8'h5a;
	localparam int SECOND = `CE_8HZ_DIV * `CE_1HZ_DIV;
	localparam int KICK_GAP = 8 * `CE_8HZ_DIV;

	logic        clk;
	logic        rst;
	logic [4:0]  csr_a;
	logic [7:0]  csr_di;
	logic        csr_we;
	logic [7:0]  csr_do;
	logic        rtc_int_n;
	logic        smb_alert_n;
	logic        sleep_n;
	logic        power_btn_n;
	logic        lid_n;
	logic        batlow_n;
	logic        charging_n;
	logic        irq_n;
	logic        wdt_time_out_n;
	logic        pcie_a_rst_n;
	logic        pcie_b_rst_n;
	logic        pcie_c_rst_n;
	logic        carrier_stby_n;
	logic        healthy_led_n;
	logic [31:0] rng;

	board_ctrl_top #(.cpld_version(VERSION)) dut (
		.clk            (clk),
		.rst            (rst),
		.csr_a          (csr_a),
		.csr_di         (csr_di),
		.csr_we         (csr_we),
		.csr_do         (csr_do),
		.rtc_int_n      (rtc_int_n),
		.smb_alert_n    (smb_alert_n),
		.sleep_n        (sleep_n),
		.power_btn_n    (power_btn_n),
		.lid_n          (lid_n),
		.batlow_n       (batlow_n),
		.charging_n     (charging_n),
		.irq_n          (irq_n),
		.wdt_time_out_n (wdt_time_out_n),
		.pcie_a_rst_n   (pcie_a_rst_n),
		.pcie_b_rst_n   (pcie_b_rst_n),
		.pcie_c_rst_n   (pcie_c_rst_n),
		.carrier_stby_n (carrier_stby_n),
		.healthy_led_n  (healthy_led_n)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("FAIL %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected));
	endtask

	// Inputs change 2 units after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
		csr_a  = addr;
		csr_di = data;
		csr_we = 1'b1;
		step();
		csr_we = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [7:0] data);
		csr_a = addr;
		step();
		data = csr_do;
	endtask

	task automatic wait_pending(input int bit_idx, input int limit);
		logic [7:0] pend;
		int         cycles;
		cycles = 0;
		read_reg(`ADDR_INT_PEND, pend);
		while (!pend[bit_idx]) begin
			cycles++;
			if (cycles > limit)
				abort_run($sformatf("timeout waiting for pending bit %0d", bit_idx));
			read_reg(`ADDR_INT_PEND, pend);
		end
	endtask

	task automatic wait_wdt_low(input int limit);
		int cycles;
		cycles = 0;
		while (wdt_time_out_n) begin
			step();
			cycles++;
			if (cycles > limit)
				abort_run("timeout waiting for the watchdog to expire");
		end
	endtask

	task automatic wait_led_toggle(output int cycles, input int limit);
		logic start;
		start  = healthy_led_n;
		cycles = 0;
		do begin
			step();
			cycles++;
			if (cycles > limit)
				abort_run("timeout waiting for the healthy LED to toggle");
		end while (healthy_led_n == start);
	endtask

	//////////////////////////////
	// Directed tests
	task automatic test_reset();
		logic [7:0] data;
		check(32'(pcie_a_rst_n), 0, "pcie_a_rst_n after reset");
		check(32'(pcie_b_rst_n), 0, "pcie_b_rst_n after reset");
		check(32'(pcie_c_rst_n), 0, "pcie_c_rst_n after reset");
		check(32'(carrier_stby_n), 1, "carrier_stby_n after reset");
		check(32'(irq_n), 1, "irq_n after reset");
		check(32'(wdt_time_out_n), 1, "wdt_time_out_n after reset");
		read_reg(`ADDR_VERSION, data);
		check(32'(data), 32'(VERSION), "VERSION register");
		read_reg(`ADDR_WDT_TIMEOUT, data);
		check(32'(data), 32'(`WDT_DEFAULT_TIMEOUT), "WDT_TIMEOUT reset value");
	endtask

	task automatic test_misc();
		logic [3:0] value;
		logic [7:0] data;
		repeat (4) begin
			rng   = xorshift32(rng);
			value = rng[3:0];
			write_reg(`ADDR_MISC_CTRL, {4'h0, value});
			read_reg(`ADDR_MISC_CTRL, data);
			check(32'(data), 32'(value), "MISC_CTRL readback");
			check(32'(pcie_a_rst_n), 32'(value[`MISC_PCIE_A]), "pcie_a_rst_n");
			check(32'(pcie_b_rst_n), 32'(value[`MISC_PCIE_B]), "pcie_b_rst_n");
			check(32'(pcie_c_rst_n), 32'(value[`MISC_PCIE_C]), "pcie_c_rst_n");
			check(32'(carrier_stby_n), 32'(!value[`MISC_CARRIER_STBY]), "carrier_stby_n");
		end
	endtask

	task automatic test_status();
		logic [4:0] levels;
		logic [7:0] data;
		rng         = xorshift32(rng);
		levels      = rng[4:0];
		lid_n       = levels[0];
		batlow_n    = levels[1];
		charging_n  = levels[2];
		sleep_n     = levels[3];
		power_btn_n = levels[4];
		repeat (4) step();
		read_reg(`ADDR_STATUS, data);
		check(32'(data), 32'({3'b000, levels}), "STATUS levels");
		lid_n       = 1'b1;
		batlow_n    = 1'b1;
		charging_n  = 1'b1;
		sleep_n     = 1'b1;
		power_btn_n = 1'b1;
		// Let edge pulses from the restore settle
		repeat (6) step();
	endtask

	task automatic test_interrupts();
		logic [4:0] enables;
		logic [7:0] data;
		repeat (3) begin
			rng     = xorshift32(rng);
			enables = rng[4:0];
			write_reg(`ADDR_INT_PEND, 8'h1f);
			write_reg(`ADDR_INT_EN, {3'b000, enables});
			rtc_int_n = 1'b0;
			step();
			rtc_int_n = 1'b1;
			wait_pending(0, 8);
			check(32'(irq_n), 32'(!enables[0]), "irq_n with rtc pending");
			write_reg(`ADDR_INT_PEND, 8'h01);
			read_reg(`ADDR_INT_PEND, data);
			check(32'(data[0]), 0, "rtc pending after clear");
			check(32'(irq_n), 1, "irq_n after clear");
		end
	endtask

	task automatic test_watchdog();
		write_reg(`ADDR_WDT_TIMEOUT, 8'd2);
		write_reg(`ADDR_INT_PEND, 8'h1f);
		write_reg(`ADDR_WDT_CTRL, 8'h01);
		repeat (4) begin
			repeat (KICK_GAP - 1) begin
				step();
				check(32'(wdt_time_out_n), 1, "wdt_time_out_n while kicked");
			end
			write_reg(`ADDR_WDT_KICK, 8'h00);
		end
		wait_wdt_low(4 * SECOND);
		wait_pending(4, 8);
		write_reg(`ADDR_WDT_KICK, 8'h00);
		check(32'(wdt_time_out_n), 1, "wdt_time_out_n after kick");
		write_reg(`ADDR_WDT_CTRL, 8'h00);
		write_reg(`ADDR_INT_PEND, 8'h1f);
	endtask

	task automatic test_led();
		int cycles;
		wait_led_toggle(cycles, 2 * SECOND);
		repeat (3) begin
			wait_led_toggle(cycles, 2 * SECOND);
			check(32'(cycles >= SECOND - 2 && cycles <= SECOND + 2), 1,
				$sformatf("healthy LED interval of %0d cycles", cycles));
		end
	endtask

	initial begin
		rst         = 1'b1;
		csr_a       = 5'h00;
		csr_di      = 8'h00;
		csr_we      = 1'b0;
		rtc_int_n   = 1'b1;
		smb_alert_n = 1'b1;
		sleep_n     = 1'b1;
		power_btn_n = 1'b1;
		lid_n       = 1'b1;
		batlow_n    = 1'b1;
		charging_n  = 1'b1;
		rng         = 32'h2497_d29a;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset();
		test_misc();
		test_status();
		test_interrupts();
		test_watchdog();
		test_led();
		$display("Simulation finished: PASS");
		$finish;
	end
endmodule

`default_nettype wire

//--- dv/board_ctrl_assertions.sv
// Interrupt and watchdog checks
`default_nettype none

module board_ctrl_assertions import board_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     irq_n,
	input irq_vec_t irq_pending,
	input irq_vec_t irq_enable,
	input logic     wdt_enable,
	input logic     wdt_expired,
	input logic     wdt_time_out_n
);
	// The request line needs an enabled pending source behind it
	irq_has_source: assert property (@(posedge clk) disable iff (rst)
		!irq_n |-> |(irq_pending & irq_enable))
		else $error("irq_n low without an enabled pending source");

	// The FSM leaves the expired state one cycle after a disable
	wdt_quiet_when_off: assert property (@(posedge clk) disable iff (rst)
		!wdt_enable |=> wdt_time_out_n)
		else $error("wdt_time_out_n low while the watchdog is disabled");

	wdt_expired_pulse: assert property (@(posedge clk) disable iff (rst)
		wdt_expired |=> !wdt_expired)
		else $error("watchdog expired pulse longer than one cycle");
endmodule

//////////////////////////////
// Interrupt controller side, watchdog ports tied idle
bind intc board_ctrl_assertions u_intc_checks (
	.clk            (clk),
	.rst            (rst),
	.irq_n          (irq_n),
	.irq_pending    (pending),
	.irq_enable     (enable),
	.wdt_enable     (1'b1),
	.wdt_expired    (1'b0),
	.wdt_time_out_n (1'b1)
);

// Watchdog side, interrupt ports tied idle
bind watchdog board_ctrl_assertions u_wdt_checks (
	.clk            (clk),
	.rst            (rst),
	.irq_n          (1'b1),
	.irq_pending    (5'b00000),
	.irq_enable     (5'b00000),
	.wdt_enable     (enable),
	.wdt_expired    (expired),
	.wdt_time_out_n (wdt_time_out_n)
);

`default_nettype wire

//--- verilog/board_ctrl_top.sv
// Board controller top level
`default_nettype none

module board_ctrl_top import csr_pkg::*, board_pkg::*; #(
	parameter csr_data_t cpld_version = 8'hff
) (
	input  logic      clk,
	input  logic      rst,
	input  csr_addr_t csr_a,
	input  csr_data_t csr_di,
	input  logic      csr_we,
	output csr_data_t csr_do,
	input  logic      rtc_int_n,
	input  logic      smb_alert_n,
	input  logic      sleep_n,
	input  logic      power_btn_n,
	input  logic      lid_n,
	input  logic      batlow_n,
	input  logic      charging_n,
	output logic      irq_n,
	output logic      wdt_time_out_n,
	output logic      pcie_a_rst_n,
	output logic      pcie_b_rst_n,
	output logic      pcie_c_rst_n,
	output logic      carrier_stby_n,
	output logic      healthy_led_n
);
	csr_if bus ();

	logic      ce_1hz;
	logic      wdt_expired;
	irq_vec_t  sync_edges;
	irq_vec_t  intc_sources;
	csr_data_t status;
	csr_data_t rdata_regs;
	csr_data_t rdata_wdt;
	csr_data_t rdata_intc;

	assign bus.addr  = csr_a;
	assign bus.wdata = csr_di;
	assign bus.we    = csr_we;

	clock_enables u_clock_enables (
		.clk    (clk),
		.rst    (rst),
		.ce_8hz (),
		.ce_1hz (ce_1hz)
	);

	input_sync u_input_sync (
		.clk         (clk),
		.rst         (rst),
		.rtc_int_n   (rtc_int_n),
		.smb_alert_n (smb_alert_n),
		.sleep_n     (sleep_n),
		.power_btn_n (power_btn_n),
		.lid_n       (lid_n),
		.batlow_n    (batlow_n),
		.charging_n  (charging_n),
		.irq_edges   (sync_edges),
		.status      (status)
	);

	board_regs u_board_regs (
		.clk            (clk),
		.rst            (rst),
		.ce_1hz         (ce_1hz),
		.version        (cpld_version),
		.status         (status),
		.bus            (bus),
		.rdata          (rdata_regs),
		.pcie_a_rst_n   (pcie_a_rst_n),
		.pcie_b_rst_n   (pcie_b_rst_n),
		.pcie_c_rst_n   (pcie_c_rst_n),
		.carrier_stby_n (carrier_stby_n),
		.healthy_led_n  (healthy_led_n)
	);

	watchdog u_watchdog (
		.clk            (clk),
		.rst            (rst),
		.ce_1hz         (ce_1hz),
		.bus            (bus),
		.rdata          (rdata_wdt),
		.expired        (wdt_expired),
		.wdt_time_out_n (wdt_time_out_n)
	);

	// Watchdog expiry is the top source bit
	assign intc_sources = sync_edges | {wdt_expired, 4'b0000};

	intc u_intc (
		.clk     (clk),
		.rst     (rst),
		.sources (intc_sources),
		.bus     (bus),
		.rdata   (rdata_intc),
		.irq_n   (irq_n)
	);

	// Units return zero outside their own addresses
	assign csr_do = rdata_regs | rdata_wdt | rdata_intc;
endmodule

`default_nettype wire

//--- verilog/intc.sv
// Interrupt controller
`default_nettype none
`include "board_defines.svh"

module intc import csr_pkg::*, board_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  irq_vec_t  sources,
	csr_if.device     bus,
	output csr_data_t rdata,
	output logic      irq_n
);
	irq_vec_t enable;
	irq_vec_t enable_next;
	irq_vec_t pending;
	irq_vec_t pending_next;
	irq_vec_t clear;

	assign clear = (bus.we && bus.addr == `ADDR_INT_PEND) ?
		bus.wdata[$bits(irq_vec_t)-1:0] : '0;

	// A new pulse wins over a clear in the same cycle
	always_comb begin
		enable_next = enable;
		if (bus.we && bus.addr == `ADDR_INT_EN)
			enable_next = bus.wdata[$bits(irq_vec_t)-1:0];
		pending_next = (pending & ~clear) | sources;
	end

	// irq_n follows the new register values so all three change together
	always_ff @(posedge clk) begin
		if (rst) begin
			enable  <= '0;
			pending <= '0;
			irq_n   <= 1'b1;
		end else begin
			enable  <= enable_next;
			pending <= pending_next;
			irq_n   <= ~|(pending_next & enable_next);
		end
	end

	always_ff @(posedge clk) begin
		case (bus.addr)
			`ADDR_INT_EN:   rdata <= csr_data_t'(enable);
			`ADDR_INT_PEND: rdata <= csr_data_t'(pending);
			default:        rdata <= '0;
		endcase
	end
endmodule

`default_nettype wire

//--- verilog/watchdog.sv
// Watchdog timer
`default_nettype none
`include "board_defines.svh"

module watchdog import csr_pkg::*, board_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ce_1hz,
	csr_if.device     bus,
	output csr_data_t rdata,
	output logic      expired,
	output logic      wdt_time_out_n
);
	wdt_state_t state;
	wdt_count_t timeout;
	wdt_count_t count;
	logic       enable;
	logic       kick;

	// Any write to the kick register counts, whatever the data
	assign kick = bus.we && (bus.addr == `ADDR_WDT_KICK);

	always_ff @(posedge clk) begin
		if (rst) begin
			enable  <= 1'b0;
			timeout <= `WDT_DEFAULT_TIMEOUT;
		end else if (bus.we) begin
			if (bus.addr == `ADDR_WDT_CTRL)
				enable <= bus.wdata[0];
			if (bus.addr == `ADDR_WDT_TIMEOUT)
				timeout <= bus.wdata;
		end
	end

	//////////////////////////////
	// Countdown FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= WDT_OFF;
			count   <= `WDT_DEFAULT_TIMEOUT;
			expired <= 1'b0;
		end else begin
			expired <= 1'b0;
			case (state)
				WDT_OFF: begin
					count <= timeout;
					if (enable)
						state <= WDT_RUN;
				end
				WDT_RUN: begin
					if (!enable) begin
						state <= WDT_OFF;
					end else if (kick) begin
						count <= timeout;
					end else if (ce_1hz) begin
						if (count == '0) begin
							state   <= WDT_EXPIRED;
							expired <= 1'b1;
						end else begin
							count <= count - 1'b1;
						end
					end
				end
				default: begin
					if (!enable) begin
						state <= WDT_OFF;
					end else if (kick) begin
						count <= timeout;
						state <= WDT_RUN;
					end
				end
			endcase
		end
	end

	// Low only in the expired state
	assign wdt_time_out_n = (state != WDT_EXPIRED);

	always_ff @(posedge clk) begin
		case (bus.addr)
			`ADDR_WDT_CTRL:    rdata <= csr_data_t'(enable);
			`ADDR_WDT_TIMEOUT: rdata <= timeout;
			`ADDR_WDT_COUNT:   rdata <= count;
			default:           rdata <= '0;
		endcase
	end
endmodule

`default_nettype wire

//--- verilog/board_regs.sv
// Board registers and slot resets
`default_nettype none
`include "board_defines.svh"

module board_regs import csr_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ce_1hz,
	input  csr_data_t version,
	input  csr_data_t status,
	csr_if.device     bus,
	output csr_data_t rdata,
	output logic      pcie_a_rst_n,
	output logic      pcie_b_rst_n,
	output logic      pcie_c_rst_n,
	output logic      carrier_stby_n,
	output logic      healthy_led_n
);
	logic [3:0] misc;
	logic       led_on;

	//////////////////////////////
	// Misc control
	always_ff @(posedge clk) begin
		if (rst)
			misc <= `MISC_RESET_VALUE;
		else if (bus.we && bus.addr == `ADDR_MISC_CTRL)
			misc <= bus.wdata[3:0];
	end

	always_ff @(posedge clk) begin
		case (bus.addr)
			`ADDR_VERSION:   rdata <= version;
			`ADDR_STATUS:    rdata <= status;
			`ADDR_MISC_CTRL: rdata <= csr_data_t'(misc);
			default:         rdata <= '0;
		endcase
	end

	// A set bit takes the slot out of reset
	assign pcie_a_rst_n = misc[`MISC_PCIE_A];
	assign pcie_b_rst_n = misc[`MISC_PCIE_B];
	assign pcie_c_rst_n = misc[`MISC_PCIE_C];

	assign carrier_stby_n = ~misc[`MISC_CARRIER_STBY];

	//////////////////////////////
	// Healthy LED, blinks once a second
	always_ff @(posedge clk) begin
		if (rst)
			led_on <= 1'b0;
		else if (ce_1hz)
			led_on <= ~led_on;
	end

	assign healthy_led_n = ~led_on;
endmodule

`default_nettype wire

//--- verilog/input_sync.sv
// Board input synchronisers
`default_nettype none

module input_sync import csr_pkg::*, board_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      rtc_int_n,
	input  logic      smb_alert_n,
	input  logic      sleep_n,
	input  logic      power_btn_n,
	input  logic      lid_n,
	input  logic      batlow_n,
	input  logic      charging_n,
	output irq_vec_t  irq_edges,
	output csr_data_t status
);
	logic [6:0] pins;
	logic [6:0] meta;
	logic [6:0] level;
	logic [6:0] level_d;
	logic [2:0] fall;
	logic       pwr_toggle;

	// Bit order rtc, smb alert, sleep, power button, lid, batlow, charging
	assign pins = {charging_n, batlow_n, lid_n, power_btn_n, sleep_n, smb_alert_n, rtc_int_n};

	assign fall       = level_d[2:0] & ~level[2:0];
	assign pwr_toggle = level_d[3] ^ level[3];

	// All pins idle high
	always_ff @(posedge clk) begin
		if (rst) begin
			meta      <= '1;
			level     <= '1;
			level_d   <= '1;
			irq_edges <= '0;
		end else begin
			meta      <= pins;
			level     <= meta;
			level_d   <= level;
			irq_edges <= {1'b0, fall[2], pwr_toggle, fall[1], fall[0]};
		end
	end

	// Power button, sleep, charging, batlow, lid
	assign status = {3'b000, level[3], level[2], level[6], level[5], level[4]};
endmodule

`default_nettype wire

//--- verilog/clock_enables.sv
// Clock-enable generator
`default_nettype none
`include "board_defines.svh"

module clock_enables (
	input  logic clk,
	input  logic rst,
	output logic ce_8hz,
	output logic ce_1hz
);
	localparam int unsigned DIV_W = $clog2(`CE_8HZ_DIV);
	localparam int unsigned SEC_W = $clog2(`CE_1HZ_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic [SEC_W-1:0] sec_cnt;

	// First stage counts clk cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			ce_8hz  <= 1'b0;
		end else begin
			ce_8hz <= (div_cnt == DIV_W'(`CE_8HZ_DIV - 1));
			if (div_cnt == DIV_W'(`CE_8HZ_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// Second stage counts 8 Hz strobes
	always_ff @(posedge clk) begin
		if (rst)
			sec_cnt <= '0;
		else if (ce_8hz)
			sec_cnt <= (sec_cnt == SEC_W'(`CE_1HZ_DIV - 1)) ? '0 : sec_cnt + 1'b1;
	end

	// Lands on the last 8 Hz strobe of each second
	assign ce_1hz = ce_8hz && (sec_cnt == SEC_W'(`CE_1HZ_DIV - 1));
endmodule

`default_nettype wire

//--- verilog/csr_if.sv
// Register bus interface
`default_nettype none

interface csr_if import csr_pkg::*; ();
	csr_addr_t addr;
	csr_data_t wdata;
	logic      we;

	// Driven from the top-level pins
	modport host (
		output addr,
		output wdata,
		output we
	);

	// Each unit decodes its own addresses
	modport device (
		input addr,
		input wdata,
		input we
	);
endinterface

`default_nettype wire

//--- verilog/board_pkg.sv
// Board function types
`default_nettype none

package board_pkg;

	// One bit per source
	// Bit 0 rtc, 1 smb alert, 2 power button, 3 sleep, 4 watchdog
	typedef logic [4:0] irq_vec_t;

	// Watchdog seconds
	typedef logic [7:0] wdt_count_t;

	typedef enum logic [1:0] {
		WDT_OFF,
		WDT_RUN,
		WDT_EXPIRED
	} wdt_state_t;

endpackage

`default_nettype wire

//--- verilog/csr_pkg.sv
// Register bus types
`default_nettype none

package csr_pkg;

	// Register address on the parallel bus
	typedef logic [4:0] csr_addr_t;

	// One register is one byte
	typedef logic [7:0] csr_data_t;

endpackage

`default_nettype wire

//--- verilog/board_defines.svh
// Board controller constants
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

//////////////////////////////
// Register addresses
`define ADDR_VERSION      5'h03
`define ADDR_WDT_CTRL     5'h04
`define ADDR_WDT_KICK     5'h05
`define ADDR_WDT_TIMEOUT  5'h06
`define ADDR_WDT_COUNT    5'h07
`define ADDR_MISC_CTRL    5'h0a
`define ADDR_STATUS       5'h1b
`define ADDR_INT_EN       5'h1c
`define ADDR_INT_PEND     5'h1d

//////////////////////////////
// Strobe dividers, scaled down for simulation
`define CE_8HZ_DIV 16
`define CE_1HZ_DIV 8

// Reset values
`define WDT_DEFAULT_TIMEOUT 8'd8
`define MISC_RESET_VALUE    4'h0

// Misc-control bits
`define MISC_PCIE_A       0
`define MISC_PCIE_B       1
`define MISC_PCIE_C       2
`define MISC_CARRIER_STBY 3

`endif
